// ==== gb_consts.svh ====
`ifndef GB_CONSTS_SVH
`define GB_CONSTS_SVH

`define GB_ADR_W        16
`define GB_DATA_W       8
`define GB_OPEN_BUS     8'hFF  // Value read when no slave drives the bus.

// Region starts of the CPU memory map. ROM sits below VRAM.
`define GB_VRAM_BASE    16'h8000
`define GB_XRAM_BASE    16'hA000
`define GB_WRAM_BASE    16'hC000  // Echo RAM above 0xE000 falls into this region too.
`define GB_OAM_BASE     16'hFE00
`define GB_IO_BASE      16'hFF00
`define GB_BROM_END     16'h00FF

// Offsets inside the I/O page. A name ending in _END is the last offset of a range.
`define GB_IO_P1        8'h00
`define GB_IO_ELP       8'h01
`define GB_IO_ELP_END   8'h02
`define GB_IO_TIM       8'h04
`define GB_IO_TIM_END   8'h07
`define GB_IO_IF        8'h0F
`define GB_IO_APU       8'h10
`define GB_IO_APU_END   8'h3F
`define GB_IO_PPU       8'h40
`define GB_IO_PPU_END   8'h4F
`define GB_IO_BROM      8'h50
`define GB_IO_HRAM      8'h80
`define GB_IO_HRAM_END  8'hFE
`define GB_IO_IE        8'hFF
`define GB_IO_DMA       8'h46  // Writing a page number here starts the OAM DMA.

`define GB_OAM_LEN      160
`define GB_RST_TICKS_W  4      // Every reset phase lasts 2**GB_RST_TICKS_W cycles.

`endif

// ==== gb_mem_pkg.sv ====
`default_nettype none
`include "gb_consts.svh"

package gb_mem_pkg;

	// Page and offset halves of a CPU address.
	typedef struct packed {
		logic [`GB_DATA_W-1:0] page;
		logic [`GB_DATA_W-1:0] offset;
	} gb_adr_pg_t;

	// The region decoder reads the flat word. The I/O decoder and the DMA read the halves.
	typedef union packed {
		logic [`GB_ADR_W-1:0] flat;
		gb_adr_pg_t           pg;
	} gb_adr_u;

	typedef struct packed {
		logic brom;
		logic vram;
		logic oam;
		logic wram;
		logic rom;
		logic xram;
		logic io;
	} mem_sel_t;

	typedef struct packed {
		logic p1;
		logic elp;
		logic tim;
		logic if_reg;  // Interrupt flag register of the CPU.
		logic apu;
		logic ppu;
		logic brom;
		logic hram;
		logic ie;
	} io_sel_t;

endpackage

`default_nettype wire

// ==== gb_bus_pkg.sv ====
`default_nettype none
`include "gb_consts.svh"

package gb_bus_pkg;

	import gb_mem_pkg::*;

	typedef struct packed {
		gb_adr_u               adr;
		logic                  rd;
		logic                  wr;
		logic [`GB_DATA_W-1:0] wdata;
	} cpu_req_t;

	// The PPU reads only. Its address is the offset inside VRAM or OAM.
	typedef struct packed {
		logic [12:0] adr;
		logic        rd;
		logic        need_vram;
		logic        need_oam;
	} ppu_req_t;

	typedef struct packed {
		logic [`GB_ADR_W-1:0]  adr;
		logic                  rd;
		logic                  wr;
		logic [`GB_DATA_W-1:0] wdata;
	} mem_port_t;

	// ROM, cartridge RAM and work RAM share one external bus.
	typedef struct packed {
		mem_port_t port;
		logic      cs_rom;
		logic      cs_xram;
		logic      cs_wram;
	} ext_port_t;

	typedef struct packed {
		logic [`GB_DATA_W-1:0] p1;
		logic [`GB_DATA_W-1:0] elp;
		logic [`GB_DATA_W-1:0] tim;
		logic [`GB_DATA_W-1:0] cpureg;  // IF and IE of the CPU.
		logic [`GB_DATA_W-1:0] apu;
		logic [`GB_DATA_W-1:0] ppu;
		logic [`GB_DATA_W-1:0] brom;
		logic [`GB_DATA_W-1:0] hram;
	} io_rdata_t;

endpackage

`default_nettype wire

// ==== gb_reset_seq.sv ====
`default_nettype none
`include "gb_consts.svh"

module gb_reset_seq (
	input  logic gbclk,
	input  logic rst_n,
	input  logic hold,
	input  logic cart_rst_n,
	output logic sys_reset,
	output logic reset_done,
	output logic cart_rst_pull
);

	typedef enum logic [1:0] {
		ST_POWER,
		ST_ASSERT,
		ST_RELEASE,
		ST_DONE
	} rst_state_t;

	rst_state_t                 state, state_nx;
	logic [`GB_RST_TICKS_W-1:0] ticks, ticks_nx;
	logic [1:0]                 hold_q;
	logic [1:0]                 cart_q;
	logic                       on_q;
	logic                       gb_on;
	logic                       cart_low;
	logic                       tick_last;

	assign gb_on     = !hold_q[1];
	assign cart_low  = !cart_q[1];
	assign tick_last = &ticks;

	always_ff @(posedge gbclk) begin
		if (!rst_n) begin
			hold_q <= '0;
			cart_q <= '1;  // The cartridge line idles high.
			on_q   <= 1'b1;
			state  <= ST_POWER;
			ticks  <= '0;
		end else begin
			hold_q <= {hold_q[0], hold};
			cart_q <= {cart_q[0], cart_rst_n};
			on_q   <= gb_on;
			state  <= state_nx;
			ticks  <= ticks_nx;
		end
	end

	// The counter wraps to zero on the last tick, which starts the next phase cleanly.
	always_comb begin
		state_nx = state;
		ticks_nx = ticks + 1'b1;
		if (state != ST_POWER && (gb_on != on_q || (state == ST_DONE && cart_low))) begin
			state_nx = ST_ASSERT;
			ticks_nx = '0;
		end else begin
			case (state)
			ST_POWER:
				if (tick_last) state_nx = ST_ASSERT;
			ST_ASSERT:
				if (tick_last) state_nx = ST_RELEASE;
			ST_RELEASE:
				if (gb_on && cart_low)
					ticks_nx = '0;  // Cartridge still holds reset.
				else if (tick_last)
					state_nx = ST_DONE;
			default:
				ticks_nx = ticks;
			endcase
		end
	end

	assign reset_done    = state == ST_DONE;
	assign sys_reset     = !reset_done || !gb_on;
	assign cart_rst_pull = state == ST_ASSERT && gb_on;

endmodule

`default_nettype wire

// ==== gb_addr_map.sv ====
`default_nettype none
`include "gb_consts.svh"

module gb_addr_map
	import gb_mem_pkg::*;
(
	input  gb_adr_u  adr,
	input  logic     enable,
	input  logic     enable_brom,
	output mem_sel_t sel
);

	// Regions are checked from the top of the map downwards.
	always_comb begin
		sel = '0;
		if (enable) begin
			if (adr.flat >= `GB_IO_BASE)
				sel.io = 1'b1;
			else if (adr.flat >= `GB_OAM_BASE)
				sel.oam = 1'b1;
			else if (adr.flat >= `GB_WRAM_BASE)
				sel.wram = 1'b1;
			else if (adr.flat >= `GB_XRAM_BASE)
				sel.xram = 1'b1;
			else if (adr.flat >= `GB_VRAM_BASE)
				sel.vram = 1'b1;
			else if (enable_brom && adr.flat <= `GB_BROM_END)
				sel.brom = 1'b1;  // The boot ROM covers the start of cartridge ROM.
			else
				sel.rom = 1'b1;
		end
	end

endmodule

`default_nettype wire

// ==== gb_io_decode.sv ====
`default_nettype none
`include "gb_consts.svh"

module gb_io_decode
	import gb_mem_pkg::*, gb_bus_pkg::*;
(
	input  logic                  gbclk,
	input  logic                  rst_n,
	input  logic                  sys_reset,
	input  cpu_req_t              cpu,
	input  logic                  io,
	output io_sel_t               sel,
	output logic                  brom_hidden,
	output logic                  dma_start,
	output logic [`GB_DATA_W-1:0] dma_page
);

	logic [`GB_DATA_W-1:0] ofs;
	logic                  dma_wr;

	assign ofs = cpu.adr.pg.offset;

	always_comb begin
		sel = '0;
		if (io) begin
			sel.p1     = ofs == `GB_IO_P1;
			sel.elp    = ofs >= `GB_IO_ELP && ofs <= `GB_IO_ELP_END;
			sel.tim    = ofs >= `GB_IO_TIM && ofs <= `GB_IO_TIM_END;
			sel.if_reg = ofs == `GB_IO_IF;
			sel.apu    = ofs >= `GB_IO_APU && ofs <= `GB_IO_APU_END;
			sel.ppu    = ofs >= `GB_IO_PPU && ofs <= `GB_IO_PPU_END;
			sel.brom   = ofs == `GB_IO_BROM;
			sel.hram   = ofs >= `GB_IO_HRAM && ofs <= `GB_IO_HRAM_END;
			sel.ie     = ofs == `GB_IO_IE;
		end
	end

	// The DMA register lives inside the PPU range.
	assign dma_wr = cpu.wr && sel.ppu && ofs == `GB_IO_DMA;

	always_ff @(posedge gbclk) begin
		if (!rst_n || sys_reset) begin
			brom_hidden <= 1'b0;
			dma_start   <= 1'b0;
		end else begin
			if (cpu.wr && sel.brom && cpu.wdata != '0)
				brom_hidden <= 1'b1;  // Once hidden the boot ROM stays hidden until reset.
			dma_start <= dma_wr;
		end
	end

	always_ff @(posedge gbclk) begin
		if (dma_wr)
			dma_page <= cpu.wdata;
	end

endmodule

`default_nettype wire

// ==== gb_oam_dma.sv ====
`default_nettype none
`include "gb_consts.svh"

module gb_oam_dma
	import gb_mem_pkg::*, gb_bus_pkg::*;
(
	input  logic                  gbclk,
	input  logic                  rst_n,
	input  logic                  sys_reset,
	input  logic                  start,
	input  logic [`GB_DATA_W-1:0] page,
	output logic                  active,
	output gb_adr_u               src_adr,
	output mem_port_t             oam_wr,
	input  logic [`GB_DATA_W-1:0] src_rdata
);

	logic [`GB_DATA_W-1:0] page_q;
	logic [`GB_DATA_W-1:0] idx;

	always_ff @(posedge gbclk) begin
		if (!rst_n || sys_reset) begin
			active <= 1'b0;
			idx    <= '0;
		end else if (start) begin
			active <= 1'b1;  // A new start also restarts a running copy.
			idx    <= '0;
		end else if (active) begin
			if (idx == `GB_DATA_W'(`GB_OAM_LEN - 1)) begin
				active <= 1'b0;
				idx    <= '0;
			end else begin
				idx <= idx + 1'b1;
			end
		end
	end

	always_ff @(posedge gbclk) begin
		if (start)
			page_q <= page;
	end

	assign src_adr.pg = {page_q, idx};

	// Each source byte goes to OAM in the cycle it is read.
	always_comb begin
		oam_wr       = '0;
		oam_wr.adr   = {{(`GB_ADR_W - `GB_DATA_W){1'b0}}, idx};
		oam_wr.wr    = active;
		oam_wr.wdata = src_rdata;
	end

endmodule

`default_nettype wire

// ==== gb_bus_arbiter.sv ====
`default_nettype none
`include "gb_consts.svh"

module gb_bus_arbiter
	import gb_mem_pkg::*, gb_bus_pkg::*;
(
	input  cpu_req_t              cpu,
	input  mem_sel_t              cpu_sel,
	input  io_sel_t               io_sel,
	input  ppu_req_t              ppu,
	input  logic                  dma_active,
	input  gb_adr_u               dma_src,
	input  mem_sel_t              dma_sel,
	input  mem_port_t             dma_oam,
	output mem_port_t             vram,
	output mem_port_t             oam,
	output ext_port_t             ext,
	input  logic [`GB_DATA_W-1:0] vram_rdata,
	input  logic [`GB_DATA_W-1:0] oam_rdata,
	input  logic [`GB_DATA_W-1:0] ext_rdata,
	input  io_rdata_t             io_rdata,
	output logic [`GB_DATA_W-1:0] cpu_rdata,
	output logic [`GB_DATA_W-1:0] dma_rdata
);

	logic cpu_ext, dma_ext;
	logic vram_blk, oam_blk, ext_blk;

	assign cpu_ext = cpu_sel.rom || cpu_sel.xram || cpu_sel.wram;
	assign dma_ext = dma_sel.rom || dma_sel.xram || dma_sel.wram;

	assign vram_blk = ppu.need_vram || (dma_active && dma_sel.vram);
	assign oam_blk  = ppu.need_oam || dma_active;
	assign ext_blk  = dma_active && dma_ext;

	// VRAM and OAM ports carry the offset inside their memory.
	always_comb begin
		vram = '0;
		if (ppu.need_vram) begin
			vram.adr = {3'b000, ppu.adr};
			vram.rd  = ppu.rd;
		end else if (dma_active && dma_sel.vram) begin
			vram.adr = {3'b000, dma_src.flat[12:0]};
			vram.rd  = 1'b1;
		end else if (cpu_sel.vram) begin
			vram.adr   = {3'b000, cpu.adr.flat[12:0]};
			vram.rd    = cpu.rd;
			vram.wr    = cpu.wr;
			vram.wdata = cpu.wdata;
		end
	end

	always_comb begin
		oam = '0;
		if (ppu.need_oam) begin
			oam.adr = {8'h00, ppu.adr[7:0]};
			oam.rd  = ppu.rd;
		end else if (dma_active) begin
			oam = dma_oam;
		end else if (cpu_sel.oam) begin
			oam.adr   = {8'h00, cpu.adr.pg.offset};
			oam.rd    = cpu.rd;
			oam.wr    = cpu.wr;
			oam.wdata = cpu.wdata;
		end
	end

	always_comb begin
		ext = '0;
		if (ext_blk) begin
			ext.port.adr = dma_src.flat;
			ext.port.rd  = 1'b1;
			ext.cs_rom   = dma_sel.rom;
			ext.cs_xram  = dma_sel.xram;
			ext.cs_wram  = dma_sel.wram;
		end else begin
			ext.port.adr   = cpu.adr.flat;
			ext.port.rd    = cpu.rd && cpu_ext;
			ext.port.wr    = cpu.wr && cpu_ext;
			ext.port.wdata = cpu.wdata;
			ext.cs_rom     = cpu_sel.rom;
			ext.cs_xram    = cpu_sel.xram;
			ext.cs_wram    = cpu_sel.wram;
		end
	end

	// At most one select is high, so the order of the items does not matter.
	always_comb begin
		cpu_rdata = `GB_OPEN_BUS;
		unique0 case (1'b1)
		io_sel.hram:                  cpu_rdata = io_rdata.hram;
		io_sel.p1:                    cpu_rdata = io_rdata.p1;
		io_sel.elp:                   cpu_rdata = io_rdata.elp;
		io_sel.tim:                   cpu_rdata = io_rdata.tim;
		io_sel.apu:                   cpu_rdata = io_rdata.apu;
		io_sel.ppu:                   cpu_rdata = io_rdata.ppu;
		io_sel.if_reg || io_sel.ie:   cpu_rdata = io_rdata.cpureg;
		cpu_sel.brom:                 cpu_rdata = io_rdata.brom;
		cpu_sel.vram && !vram_blk:    cpu_rdata = vram_rdata;
		cpu_sel.oam && !oam_blk:      cpu_rdata = oam_rdata;
		cpu_ext && !ext_blk:          cpu_rdata = ext_rdata;
		endcase
	end

	always_comb begin
		dma_rdata = `GB_OPEN_BUS;
		if (dma_sel.vram && !ppu.need_vram)
			dma_rdata = vram_rdata;
		else if (dma_ext)
			dma_rdata = ext_rdata;
	end

endmodule

`default_nettype wire

// ==== gb_bus_fabric.sv ====
`default_nettype none
`include "gb_consts.svh"

module gb_bus_fabric
	import gb_mem_pkg::*, gb_bus_pkg::*;
(
	input  logic                  gbclk,
	input  logic                  rst_n,
	input  logic                  hold,
	input  logic                  cart_rst_n,
	output logic                  cart_rst_pull,
	output logic                  sys_reset,
	output logic                  reset_done,
	input  cpu_req_t              cpu_req,
	output logic [`GB_DATA_W-1:0] cpu_rdata,
	input  ppu_req_t              ppu_req,
	output mem_port_t             vram,
	input  logic [`GB_DATA_W-1:0] vram_rdata,
	output mem_port_t             oam,
	input  logic [`GB_DATA_W-1:0] oam_rdata,
	output ext_port_t             ext,
	input  logic [`GB_DATA_W-1:0] ext_rdata,
	output io_sel_t               io_sel,
	input  io_rdata_t             io_rdata
);

	mem_sel_t              cpu_sel;
	mem_sel_t              dma_sel;
	logic                  brom_hidden;
	logic                  dma_start;
	logic [`GB_DATA_W-1:0] dma_page;
	logic                  dma_active;
	gb_adr_u               dma_src;
	mem_port_t             dma_oam;
	logic [`GB_DATA_W-1:0] dma_rdata;

	gb_reset_seq reset_seq_i (
		.gbclk(gbclk), .rst_n(rst_n), .hold(hold), .cart_rst_n(cart_rst_n),
		.sys_reset(sys_reset), .reset_done(reset_done), .cart_rst_pull(cart_rst_pull)
	);

	gb_addr_map cpu_map_i (
		.adr(cpu_req.adr), .enable(1'b1), .enable_brom(!brom_hidden), .sel(cpu_sel)
	);

	// The DMA never reads the boot ROM.
	gb_addr_map dma_map_i (
		.adr(dma_src), .enable(dma_active), .enable_brom(1'b0), .sel(dma_sel)
	);

	gb_io_decode io_decode_i (
		.gbclk(gbclk), .rst_n(rst_n), .sys_reset(sys_reset), .cpu(cpu_req),
		.io(cpu_sel.io), .sel(io_sel), .brom_hidden(brom_hidden),
		.dma_start(dma_start), .dma_page(dma_page)
	);

	gb_oam_dma oam_dma_i (
		.gbclk(gbclk), .rst_n(rst_n), .sys_reset(sys_reset), .start(dma_start),
		.page(dma_page), .active(dma_active), .src_adr(dma_src), .oam_wr(dma_oam),
		.src_rdata(dma_rdata)
	);

	gb_bus_arbiter bus_arbiter_i (
		.cpu(cpu_req), .cpu_sel(cpu_sel), .io_sel(io_sel), .ppu(ppu_req),
		.dma_active(dma_active), .dma_src(dma_src), .dma_sel(dma_sel), .dma_oam(dma_oam),
		.vram(vram), .oam(oam), .ext(ext),
		.vram_rdata(vram_rdata), .oam_rdata(oam_rdata), .ext_rdata(ext_rdata),
		.io_rdata(io_rdata), .cpu_rdata(cpu_rdata), .dma_rdata(dma_rdata)
	);

endmodule

`default_nettype wire

// ==== tb_gb_bus_fabric.sv ====
`default_nettype none
`include "gb_consts.svh"

module tb_gb_bus_fabric
	import gb_mem_pkg::*, gb_bus_pkg::*;
();

	timeunit 1ns;
	timeprecision 100ps;

	typedef enum logic [2:0] {
		PT_NONE,
		PT_VRAM,
		PT_OAM,
		PT_ROM,
		PT_XRAM,
		PT_WRAM,
		PT_IO,
		PT_BROM
	} port_e;

	typedef struct packed {
		logic [15:0] adr;
		logic        wr;
		logic [7:0]  wdata;
		logic        need_vram;
		logic        need_oam;
		port_e       port;
		logic [8:0]  io;    // Expected io_sel with p1 in the top bit.
	} row_t;

	localparam int RST_PHASE   = 1 << `GB_RST_TICKS_W;
	localparam int SYNC_STAGES = 2;
	localparam int HOLD_CYCLES = 20;
	localparam int CART_LOW    = 24;
	localparam int WAIT_LIMIT  = 200;
	localparam logic [12:0] PPU_ADR = 13'h1A5C;

	localparam logic [8:0] IOS_P1   = 9'h100;
	localparam logic [8:0] IOS_ELP  = 9'h080;
	localparam logic [8:0] IOS_TIM  = 9'h040;
	localparam logic [8:0] IOS_IF   = 9'h020;
	localparam logic [8:0] IOS_APU  = 9'h010;
	localparam logic [8:0] IOS_PPU  = 9'h008;
	localparam logic [8:0] IOS_BROM = 9'h004;
	localparam logic [8:0] IOS_HRAM = 9'h002;
	localparam logic [8:0] IOS_IE   = 9'h001;

	// Each slave mixes its own key into the row salt, so every source reads differently.
	localparam logic [7:0] K_P1   = 8'd1;
	localparam logic [7:0] K_ELP  = 8'd2;
	localparam logic [7:0] K_TIM  = 8'd3;
	localparam logic [7:0] K_CPU  = 8'd4;
	localparam logic [7:0] K_APU  = 8'd5;
	localparam logic [7:0] K_PPU  = 8'd6;
	localparam logic [7:0] K_BROM = 8'd7;
	localparam logic [7:0] K_HRAM = 8'd8;
	localparam logic [7:0] K_VRAM = 8'd9;
	localparam logic [7:0] K_OAM  = 8'd10;
	localparam logic [7:0] K_EXT  = 8'd11;

	logic                  gbclk;
	logic                  rst_n;
	logic                  hold;
	logic                  cart_rst_n;
	logic                  cart_rst_pull;
	logic                  sys_reset;
	logic                  reset_done;
	cpu_req_t              cpu_req;
	logic [`GB_DATA_W-1:0] cpu_rdata;
	ppu_req_t              ppu_req;
	mem_port_t             vram;
	mem_port_t             oam;
	ext_port_t             ext;
	logic [`GB_DATA_W-1:0] vram_rdata;
	logic [`GB_DATA_W-1:0] oam_rdata;
	logic [`GB_DATA_W-1:0] ext_rdata;
	io_sel_t               io_sel;
	io_rdata_t             io_rdata;

	row_t rows [0:47];
	int   n_rows;

	gb_bus_fabric dut_i (
		.gbclk(gbclk), .rst_n(rst_n), .hold(hold), .cart_rst_n(cart_rst_n),
		.cart_rst_pull(cart_rst_pull), .sys_reset(sys_reset), .reset_done(reset_done),
		.cpu_req(cpu_req), .cpu_rdata(cpu_rdata), .ppu_req(ppu_req),
		.vram(vram), .vram_rdata(vram_rdata), .oam(oam), .oam_rdata(oam_rdata),
		.ext(ext), .ext_rdata(ext_rdata), .io_sel(io_sel), .io_rdata(io_rdata)
	);

	initial begin
		gbclk = 1'b0;
		forever #4 gbclk = ~gbclk;
	end

	task automatic stop_on_error(input string what);
		$display("%s", what);
		$display("Testbench failed");
		$fatal(1, "Simulation stopped at the first error.");
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		if (got !== exp)
			stop_on_error($sformatf("** Error: %s is 0x%0h, expected 0x%0h", name, got, exp));
	endtask

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	// Multiplying by an odd number keeps the low byte unique per address.
	function automatic logic [7:0] slave_byte(input logic [15:0] adr, input logic [7:0] salt);
		return (adr[7:0] * 8'd7) ^ adr[15:8] ^ salt;
	endfunction

	function automatic io_rdata_t io_bytes(input logic [15:0] adr, input logic [7:0] salt);
		io_rdata_t d;
		d.p1     = slave_byte(adr, salt + K_P1);
		d.elp    = slave_byte(adr, salt + K_ELP);
		d.tim    = slave_byte(adr, salt + K_TIM);
		d.cpureg = slave_byte(adr, salt + K_CPU);
		d.apu    = slave_byte(adr, salt + K_APU);
		d.ppu    = slave_byte(adr, salt + K_PPU);
		d.brom   = slave_byte(adr, salt + K_BROM);
		d.hram   = slave_byte(adr, salt + K_HRAM);
		return d;
	endfunction

	function automatic logic [7:0] io_key(input logic [8:0] io);
		case (io)
		IOS_P1:         return K_P1;
		IOS_ELP:        return K_ELP;
		IOS_TIM:        return K_TIM;
		IOS_IF, IOS_IE: return K_CPU;
		IOS_APU:        return K_APU;
		IOS_PPU:        return K_PPU;
		IOS_HRAM:       return K_HRAM;
		default:        return 8'd0;  // Unmapped offsets and the write-only hide latch.
		endcase
	endfunction

	// A key of zero stands for a read that nobody answers.
	function automatic logic [7:0] expected_rdata(input row_t r, input logic [7:0] salt);
		logic [7:0] key;
		case (r.port)
		PT_VRAM:                  key = r.need_vram ? 8'd0 : K_VRAM;
		PT_OAM:                   key = r.need_oam ? 8'd0 : K_OAM;
		PT_ROM, PT_XRAM, PT_WRAM: key = K_EXT;
		PT_BROM:                  key = K_BROM;
		PT_IO:                    key = io_key(r.io);
		default:                  key = 8'd0;
		endcase
		if (key == 8'd0)
			return `GB_OPEN_BUS;
		return slave_byte(r.adr, salt + key);
	endfunction

	task automatic add_row(input logic [15:0] adr, input logic wr, input logic [7:0] wdata,
			input logic nv, input logic no, input port_e port, input logic [8:0] io);
		rows[n_rows] = {adr, wr, wdata, nv, no, port, io};
		n_rows = n_rows + 1;
	endtask

	task automatic fill_table();
		n_rows = 0;
		add_row(16'h0000, 0, 8'h00, 0, 0, PT_BROM, 9'h000);
		add_row(16'h00FF, 0, 8'h00, 0, 0, PT_BROM, 9'h000);
		add_row(16'h0100, 0, 8'h00, 0, 0, PT_ROM, 9'h000);
		add_row(16'h4000, 1, 8'h5A, 0, 0, PT_ROM, 9'h000);
		add_row(16'h8000, 0, 8'h00, 0, 0, PT_VRAM, 9'h000);
		add_row(16'h9FFF, 1, 8'h3C, 0, 0, PT_VRAM, 9'h000);
		add_row(16'hA000, 0, 8'h00, 0, 0, PT_XRAM, 9'h000);
		add_row(16'hBFFF, 1, 8'hA7, 0, 0, PT_XRAM, 9'h000);
		add_row(16'hC000, 0, 8'h00, 0, 0, PT_WRAM, 9'h000);
		add_row(16'hE123, 0, 8'h00, 0, 0, PT_WRAM, 9'h000);  // Echo RAM.
		add_row(16'hFDFF, 1, 8'h91, 0, 0, PT_WRAM, 9'h000);
		add_row(16'hFE00, 0, 8'h00, 0, 0, PT_OAM, 9'h000);
		add_row(16'hFE9F, 1, 8'h42, 0, 0, PT_OAM, 9'h000);
		add_row(16'hFF00, 0, 8'h00, 0, 0, PT_IO, IOS_P1);
		add_row(16'hFF02, 0, 8'h00, 0, 0, PT_IO, IOS_ELP);
		add_row(16'hFF03, 0, 8'h00, 0, 0, PT_IO, 9'h000);
		add_row(16'hFF07, 0, 8'h00, 0, 0, PT_IO, IOS_TIM);
		add_row(16'hFF0F, 0, 8'h00, 0, 0, PT_IO, IOS_IF);
		add_row(16'hFF10, 0, 8'h00, 0, 0, PT_IO, IOS_APU);
		add_row(16'hFF3F, 0, 8'h00, 0, 0, PT_IO, IOS_APU);
		add_row(16'hFF46, 0, 8'h00, 0, 0, PT_IO, IOS_PPU);
		add_row(16'hFF4F, 0, 8'h00, 0, 0, PT_IO, IOS_PPU);
		add_row(16'hFF50, 1, 8'h00, 0, 0, PT_IO, IOS_BROM);  // Zero leaves the boot ROM in.
		add_row(16'hFF60, 0, 8'h00, 0, 0, PT_IO, 9'h000);
		add_row(16'hFF80, 0, 8'h00, 0, 0, PT_IO, IOS_HRAM);
		add_row(16'hFFFE, 0, 8'h00, 0, 0, PT_IO, IOS_HRAM);
		add_row(16'hFFFF, 0, 8'h00, 0, 0, PT_IO, IOS_IE);
		add_row(16'h8123, 0, 8'h00, 1, 0, PT_VRAM, 9'h000);
		add_row(16'h8123, 1, 8'hEE, 1, 0, PT_VRAM, 9'h000);
		add_row(16'hFE05, 0, 8'h00, 0, 1, PT_OAM, 9'h000);
		add_row(16'h9000, 0, 8'h00, 0, 1, PT_VRAM, 9'h000);
		add_row(16'hFF50, 1, 8'h01, 0, 0, PT_IO, IOS_BROM);
		add_row(16'h0000, 0, 8'h00, 0, 0, PT_ROM, 9'h000);
		add_row(16'h00FF, 0, 8'h00, 0, 0, PT_ROM, 9'h000);
	endtask

	task automatic apply_row(input row_t r, input logic [7:0] salt);
		logic [1:0] strobe;
		logic [1:0] vram_exp;
		logic [1:0] oam_exp;
		logic       ext_hit;
		strobe   = {!r.wr, r.wr};
		ext_hit  = r.port == PT_ROM || r.port == PT_XRAM || r.port == PT_WRAM;
		vram_exp = r.need_vram ? 2'b10 : (r.port == PT_VRAM ? strobe : 2'b00);
		oam_exp  = r.need_oam ? 2'b10 : (r.port == PT_OAM ? strobe : 2'b00);
		@(posedge gbclk);
		cpu_req    <= {r.adr, !r.wr, r.wr, r.wdata};
		ppu_req    <= {PPU_ADR, r.need_vram || r.need_oam, r.need_vram, r.need_oam};
		vram_rdata <= slave_byte(r.adr, salt + K_VRAM);
		oam_rdata  <= slave_byte(r.adr, salt + K_OAM);
		ext_rdata  <= slave_byte(r.adr, salt + K_EXT);
		io_rdata   <= io_bytes(r.adr, salt);
		@(negedge gbclk);
		check_value("{vram.rd, vram.wr}", {vram.rd, vram.wr}, vram_exp);
		check_value("{oam.rd, oam.wr}", {oam.rd, oam.wr}, oam_exp);
		check_value("{ext.port.rd, ext.port.wr}", {ext.port.rd, ext.port.wr},
			ext_hit ? strobe : 2'b00);
		check_value("ext.port.adr", ext.port.adr, r.adr);
		check_value("{ext.cs_rom, ext.cs_xram, ext.cs_wram}",
			{ext.cs_rom, ext.cs_xram, ext.cs_wram},
			{r.port == PT_ROM, r.port == PT_XRAM, r.port == PT_WRAM});
		check_value("io_sel", io_sel, r.io);
		if (r.need_vram)
			check_value("vram.adr", vram.adr, {3'b000, PPU_ADR});
		else if (r.port == PT_VRAM)
			check_value("vram.adr", vram.adr, {3'b000, r.adr[12:0]});
		if (r.need_oam)
			check_value("oam.adr", oam.adr, {8'h00, PPU_ADR[7:0]});
		else if (r.port == PT_OAM)
			check_value("oam.adr", oam.adr, {8'h00, r.adr[7:0]});
		if (vram_exp == 2'b01)
			check_value("vram.wdata", vram.wdata, r.wdata);
		if (oam_exp == 2'b01)
			check_value("oam.wdata", oam.wdata, r.wdata);
		if (r.wr && ext_hit)
			check_value("ext.port.wdata", ext.port.wdata, r.wdata);
		if (!r.wr)
			check_value("cpu_rdata", cpu_rdata, expected_rdata(r, salt));
	endtask

	task automatic wait_reset_done(output int cycles, output int pull_cycles);
		cycles      = 0;
		pull_cycles = 0;
		do begin
			@(posedge gbclk);
			cycles = cycles + 1;
			@(negedge gbclk);
			if (cart_rst_pull)
				pull_cycles = pull_cycles + 1;
			if (cycles > WAIT_LIMIT)
				stop_on_error("reset_done did not rise within the timeout.");
		end while (!reset_done);
	endtask

	// The source page lies in work RAM, so the copy runs over the external port.
	task automatic run_dma(input logic [7:0] page, input logic [7:0] salt);
		logic [15:0] src;
		@(posedge gbclk);
		cpu_req <= {8'hFF, `GB_IO_DMA, 1'b0, 1'b1, page};
		ppu_req <= '0;
		@(posedge gbclk);
		cpu_req <= '0;  // The write is taken at this edge.
		@(negedge gbclk);
		check_value("oam.wr", oam.wr, 1'b0);
		for (int i = 0; i < `GB_OAM_LEN; i++) begin
			src = {page, 8'(i)};
			@(posedge gbclk);
			ext_rdata <= slave_byte(src, salt);
			cpu_req   <= {16'hFE10, 1'b1, 1'b0, 8'h00};
			@(negedge gbclk);
			check_value("oam.wr", oam.wr, 1'b1);
			check_value("oam.adr", oam.adr, i);
			check_value("oam.wdata", oam.wdata, slave_byte(src, salt));
			check_value("ext.port.adr", ext.port.adr, src);
			check_value("ext.cs_wram", ext.cs_wram, 1'b1);
			check_value("cpu_rdata", cpu_rdata, `GB_OPEN_BUS);
		end
		@(posedge gbclk);
		oam_rdata <= slave_byte(16'hFE10, salt + K_OAM);
		@(negedge gbclk);
		check_value("oam.wr", oam.wr, 1'b0);
		check_value("cpu_rdata", cpu_rdata, slave_byte(16'hFE10, salt + K_OAM));
		@(posedge gbclk);
		cpu_req <= '0;
	endtask

	initial begin
		int          cycles;
		int          pulls;
		logic [31:0] lcg;
		rst_n      = 1'b0;
		hold       = 1'b0;
		cart_rst_n = 1'b1;
		cpu_req    = '0;
		ppu_req    = '0;
		vram_rdata = '0;
		oam_rdata  = '0;
		ext_rdata  = '0;
		io_rdata   = '0;
		lcg        = 32'd12570;
		fill_table();
		repeat (16) @(posedge gbclk);
		rst_n <= 1'b1;
		wait_reset_done(cycles, pulls);
		check_value("power-up cycles to reset_done", cycles, 3 * RST_PHASE);
		check_value("cart_rst_pull cycles", pulls, RST_PHASE);
		check_value("sys_reset", sys_reset, 1'b0);

		@(posedge gbclk);
		hold <= 1'b1;
		repeat (HOLD_CYCLES - 1) @(posedge gbclk);
		@(negedge gbclk);
		check_value("sys_reset", sys_reset, 1'b1);
		check_value("reset_done", reset_done, 1'b0);
		check_value("cart_rst_pull", cart_rst_pull, 1'b0);
		@(posedge gbclk);
		hold <= 1'b0;
		wait_reset_done(cycles, pulls);
		// Two synchronizer flops, one edge to see the change, then assert and release.
		check_value("cycles to reset_done after hold", cycles, SYNC_STAGES + 1 + 2 * RST_PHASE);
		check_value("cart_rst_pull cycles", pulls, RST_PHASE);

		@(posedge gbclk);
		cart_rst_n <= 1'b0;
		repeat (CART_LOW - 1) @(posedge gbclk);
		@(negedge gbclk);
		check_value("reset_done", reset_done, 1'b0);
		check_value("cart_rst_pull", cart_rst_pull, 1'b0);
		@(posedge gbclk);
		cart_rst_n <= 1'b1;
		wait_reset_done(cycles, pulls);
		// The release count starts over until the synchronized line is high again.
		check_value("cycles to reset_done after cartridge reset", cycles,
			SYNC_STAGES + RST_PHASE);

		for (int k = 0; k < n_rows; k++) begin
			lcg = lcg_next(lcg);
			apply_row(rows[k], lcg[23:16]);
		end
		lcg = lcg_next(lcg);
		run_dma(8'hC1, lcg[23:16]);

		$display("Testbench passed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== gb_bus_fabric.f ====
+incdir+.
gb_mem_pkg.sv
gb_bus_pkg.sv
gb_reset_seq.sv
gb_addr_map.sv
gb_io_decode.sv
gb_oam_dma.sv
gb_bus_arbiter.sv
gb_bus_fabric.sv
tb_gb_bus_fabric.sv
